// File: list.f
verilog/ranger_pkg.sv
verilog/ranger_regs.sv
verilog/trig_scheduler.sv
verilog/echo_timer.sv
verilog/ranger_top.sv
testbench/ranger_assertions.sv
testbench/tb_ranger.sv

// File: Bender.yml
package:
  name: ranger

sources:
  - verilog/ranger_pkg.sv
  - verilog/ranger_regs.sv
  - verilog/trig_scheduler.sv
  - verilog/echo_timer.sv
  - verilog/ranger_top.sv
  - target: test
    files:
      - testbench/ranger_assertions.sv
      - testbench/tb_ranger.sv

// File: testbench/tb_ranger.sv
module tb_ranger;

    timeunit 1ns;
    timeprecision 100ps;

    import ranger_pkg::*;

    localparam int          sync_stages  = 2;
    localparam int unsigned test_period  = 500;
    localparam int unsigned test_trig    = 4;
    localparam int unsigned test_cpcm    = 7;
    localparam int unsigned test_timeout = 400;
    localparam int          trig_limit   = 2000;   // Cycles
    localparam int          poll_limit   = 600;    // Reads of reg_result

    logic                   clk;
    logic                   rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [addr_width-1:0]  paddr;
    logic [reg_width-1:0]   pwdata;
    logic [reg_width-1:0]   prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   trig;
    logic                   echo;
    logic                   irq;

    logic [31:0]            rng_state = 32'ha608_20f3;
    logic                   sensor_on;
    int unsigned            fixed_len;           // Zero selects a random echo length
    int unsigned            echo_lens[$];        // Echo lengths in the order they were sent
    int                     n_meas;
    int                     check_count;
    int                     err_count;

    ranger_top
    #(
        .sync_stages (sync_stages)
    )
    dut0
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .trig    (trig),
        .echo    (echo),
        .irq     (irq)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Register image of one measurement in whole centimeters, or overflow once L reaches timeout
    function automatic logic [31:0] expected_result(input int unsigned len,
                                                    input int unsigned cpcm,
                                                    input int unsigned tmo);
        logic [31:0] value;
        value = '0;
        value[result_valid_bit] = 1'b1;
        if (len >= tmo)
        begin
            value[result_timed_out_bit] = 1'b1;
            value[dist_width-1:0]       = dist_overflow;
        end
        else
            value[dist_width-1:0] = dist_width'(len / cpcm);
        return value;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            err_count++;
        end
    endtask

    // Setup and access phase; starts and ends 10 ns after a rising edge
    task automatic apb_transfer(input logic write, input logic [addr_width-1:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        logic ready;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        next_cycle();
        penable = 1'b1;
        #40;                                // Mid access phase
        rdata = prdata;
        err   = pslverr;
        ready = pready;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        check_value("pready", 32'd1, ready);
    endtask

    task automatic apb_write(input logic [addr_width-1:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [addr_width-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic wait_trig(input logic level, output int cycles);
        cycles = 0;
        while (trig !== level && cycles < trig_limit)
        begin
            next_cycle();
            cycles++;
        end
        if (trig !== level)
        begin
            $display("Timed out waiting for trig to become %0b", level);
            err_count++;
        end
    endtask

    task automatic wait_irq();
        int cycles;
        cycles = 0;
        while (irq !== 1'b1 && cycles < 2 * test_period)
        begin
            next_cycle();
            cycles++;
        end
        if (irq !== 1'b1)
        begin
            $display("Timed out waiting for irq to rise");
            err_count++;
        end
    endtask

    task automatic wait_result(output logic [31:0] value, output logic ok);
        logic err;
        int   polls;
        polls = 0;
        do
        begin
            apb_read(reg_result, value, err);
            polls++;
        end
        while (!value[result_valid_bit] && polls < poll_limit);
        ok = value[result_valid_bit];
        if (!ok)
        begin
            $display("Timed out polling reg_result for a valid measurement");
            err_count++;
        end
    endtask

    // Compare one result with the reference, then confirm that the read cleared valid
    task automatic measure_check(input string name);
        logic [31:0] value;
        logic [31:0] again;
        logic        err;
        logic        ok;
        int unsigned len;
        wait_result(value, ok);
        if (ok)
        begin
            if (echo_lens.size() == 0)
            begin
                $display("A %s result arrived with no echo sent", name);
                err_count++;
            end
            else
            begin
                len = echo_lens.pop_front();
                check_value(name, expected_result(len, test_cpcm, test_timeout), value);
                apb_read(reg_result, again, err);
                check_value({name, " valid after read"}, 32'd0, again[result_valid_bit]);
                n_meas++;
            end
        end
    endtask

    // Sensor model answering each trig pulse with one echo
    initial
    begin : sensor_model
        logic        trig_prev;
        int unsigned gap;
        int unsigned len;
        echo      = 1'b0;
        trig_prev = 1'b0;
        forever
        begin
            next_cycle();
            if (sensor_on && trig_prev && !trig)
            begin
                rng_state = xorshift(rng_state);
                gap       = 2 + rng_state % 8;
                rng_state = xorshift(rng_state);
                len       = (fixed_len != 0) ? fixed_len : 20 + rng_state % 280;
                repeat (gap) next_cycle();
                echo_lens.push_back(len);
                echo = 1'b1;
                repeat (len) next_cycle();
                echo = 1'b0;
            end
            trig_prev = trig;
        end
    end

    initial
    begin : main_seq
        logic [addr_width-1:0] addrs[5];
        logic [31:0]           values[5];
        logic [31:0]           rdata;
        logic [31:0]           count_before;
        logic                  err;
        int                    hi;
        int                    lo;
        int                    high_seen;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        rst_n       = 1'b0;
        sensor_on   = 1'b0;
        fixed_len   = 0;
        n_meas      = 0;
        check_count = 0;
        err_count   = 0;
        repeat (5) @(posedge clk);
        #10;
        rst_n = 1'b1;
        next_cycle();

        // Register write and read back
        addrs  = '{reg_period, reg_trig_len, reg_cycles_per_cm, reg_timeout, reg_ctrl};
        values = '{32'h0012_3456, 32'h0000_0abc, 32'h0000_1111, 32'h000f_0f0f, 32'h2};
        for (int i = 0; i < 5; i++)
        begin
            apb_write(addrs[i], values[i], err);
            check_value($sformatf("write error 0x%02h", addrs[i]), 32'd0, err);
        end
        for (int i = 0; i < 5; i++)
        begin
            apb_read(addrs[i], rdata, err);
            check_value($sformatf("readback 0x%02h", addrs[i]), values[i], rdata);
        end
        apb_read(8'h20, rdata, err);
        check_value("unmapped read error", 32'd1, err);
        apb_write(reg_result, 32'h1234, err);
        check_value("reg_result write error", 32'd1, err);
        apb_write(reg_count, 32'h1, err);
        check_value("reg_count write error", 32'd1, err);

        // Trigger pulse shape
        apb_write(reg_period, 32'd20, err);
        apb_write(reg_trig_len, 32'd3, err);
        apb_write(reg_ctrl, 32'h1, err);
        wait_trig(1'b1, hi);
        wait_trig(1'b0, hi);
        wait_trig(1'b1, lo);
        check_value("trig high cycles", 32'd3, hi);
        check_value("trig period", 32'd20, hi + lo);
        apb_write(reg_ctrl, 32'h0, err);

        // Random distances below the timeout
        apb_write(reg_period, test_period, err);
        apb_write(reg_trig_len, test_trig, err);
        apb_write(reg_cycles_per_cm, test_cpcm, err);
        apb_write(reg_timeout, test_timeout, err);
        sensor_on = 1'b1;
        apb_write(reg_ctrl, 32'h1, err);
        for (int i = 0; i < 6; i++)
            measure_check($sformatf("distance %0d", i));

        // Echo outlasting the timeout
        fixed_len = test_timeout + 20;
        measure_check("timeout");
        fixed_len = 0;

        // Interrupt follows the pending result
        apb_write(reg_ctrl, 32'h3, err);
        wait_irq();
        measure_check("irq distance");
        check_value("irq after read", 32'd0, irq);
        apb_read(reg_count, rdata, err);
        check_value("measurement count", n_meas, rdata);

        // Disable just after a trig pulse so an echo arrives while disabled
        apb_read(reg_count, count_before, err);
        wait_trig(1'b1, hi);
        wait_trig(1'b0, hi);
        apb_write(reg_ctrl, 32'h0, err);
        high_seen = 0;
        repeat (3 * test_period)
        begin
            next_cycle();
            if (trig !== 1'b0)
                high_seen++;
        end
        if (high_seen != 0)
        begin
            $display("trig was high for %0d cycles while disabled", high_seen);
            err_count++;
        end
        apb_read(reg_count, rdata, err);
        check_value("count while disabled", count_before, rdata);

        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: testbench/ranger_assertions.sv
module ranger_assertions
(
    input logic clk,
    input logic rst_n,
    input logic pready,
    input logic enable,
    input logic trig,
    input logic irq,
    input logic irq_en
);

    timeunit 1ns;
    timeprecision 100ps;

    // Every APB transfer completes without wait states
    pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready was low");

    // Trig is registered, so it lags enable by one cycle
    trig_low_disabled: assert property (@(posedge clk) disable iff (!rst_n)
                                        !$past(enable) |-> !trig)
        else $error("trig high while the ranger is disabled");

    irq_needs_enable: assert property (@(posedge clk) disable iff (!rst_n) irq |-> irq_en)
        else $error("irq raised with interrupt enable clear");

endmodule

bind ranger_top ranger_assertions u_assertions
(
    .clk    (clk),
    .rst_n  (rst_n),
    .pready (pready),
    .enable (cfg.enable),
    .trig   (trig),
    .irq    (irq),
    .irq_en (u_regs.irq_en)
);

// File: verilog/ranger_top.sv
module ranger_top
#(
    parameter int sync_stages = 2       // Echo synchronizer depth, 2 or 3
)
(
    input  logic                                clk,
    input  logic                                rst_n,

    // APB slave
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [ranger_pkg::addr_width-1:0]   paddr,
    input  logic [ranger_pkg::reg_width-1:0]    pwdata,
    output logic [ranger_pkg::reg_width-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr,

    // Sensor pins
    output logic                                trig,
    input  logic                                echo,

    output logic                                irq
);

    import ranger_pkg::*;

    ranger_cfg_t  cfg;
    echo_result_t result;
    logic         arm;

    ranger_regs u_regs
    (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .result  (result),
        .cfg     (cfg),
        .irq     (irq)
    );

    trig_scheduler u_sched
    (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .trig  (trig),
        .arm   (arm)
    );

    echo_timer
    #(
        .sync_stages (sync_stages)
    )
    u_echo
    (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .arm    (arm),
        .echo   (echo),
        .result (result)
    );

endmodule

// File: verilog/echo_timer.sv
module echo_timer
#(
    parameter int sync_stages = 2
)
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  ranger_pkg::ranger_cfg_t   cfg,
    input  logic                      arm,
    input  logic                      echo,
    output ranger_pkg::echo_result_t  result
);

    import ranger_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_armed,
        st_measuring
    } state_t;

    state_t                 state;
    logic [sync_stages-1:0] sync_q;
    logic                   echo_s;
    logic                   echo_d;
    logic                   echo_rise;
    logic                   echo_fall;

    logic                   counting;
    logic                   hit_timeout;
    logic                   finish;
    logic [cycle_width-1:0] total_cnt;
    logic [cycle_width-1:0] total_next;
    logic [cycle_width-1:0] presc_cnt;
    logic [cycle_width-1:0] presc_next;
    logic [dist_width-1:0]  cm_cnt;
    logic [dist_width-1:0]  cm_next;

    logic                   done_q;
    logic                   timed_out_q;
    logic [dist_width-1:0]  distance_q;

    // Echo pin is asynchronous to clk
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            sync_q <= '0;
            echo_d <= 1'b0;
        end
        else
        begin
            sync_q <= {sync_q[sync_stages-2:0], echo};
            echo_d <= echo_s;
        end
    end

    assign echo_s    = sync_q[sync_stages-1];
    assign echo_rise = echo_s & ~echo_d;
    assign echo_fall = ~echo_s & echo_d;

    // Every cycle with the synchronized echo high is one count
    assign counting = (state == st_armed && echo_rise) || (state == st_measuring && echo_s);

    always_comb
    begin
        total_next = total_cnt + 1'b1;
        presc_next = presc_cnt + 1'b1;
        cm_next    = cm_cnt;
        if (presc_next == cfg.cycles_per_cm)
        begin
            presc_next = '0;
            if (cm_cnt != dist_overflow)
                cm_next = cm_cnt + 1'b1;    // Saturates
        end
    end

    assign hit_timeout = counting && (total_next >= cfg.timeout);
    assign finish      = cfg.enable &&
                         (hit_timeout || (state == st_measuring && echo_fall));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= st_idle;
        else if (!cfg.enable)
            state <= st_idle;
        else
        begin
            case (state)
                st_idle:
                    if (arm)
                        state <= st_armed;
                st_armed:
                    if (finish)
                        state <= st_idle;
                    else if (echo_rise)
                        state <= st_measuring;
                st_measuring:
                    if (finish)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Cycle, prescaler and centimeter counters
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            total_cnt <= '0;
            presc_cnt <= '0;
            cm_cnt    <= '0;
        end
        else if (arm && state != st_measuring)
        begin
            total_cnt <= '0;
            presc_cnt <= '0;
            cm_cnt    <= '0;
        end
        else if (counting)
        begin
            total_cnt <= total_next;
            presc_cnt <= presc_next;
            cm_cnt    <= cm_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            done_q <= 1'b0;
        else
            done_q <= finish;
    end

    // Result payload, captured on the finishing cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            timed_out_q <= 1'b0;
            distance_q  <= '0;
        end
        else if (finish)
        begin
            timed_out_q <= hit_timeout;
            distance_q  <= hit_timeout ? dist_overflow : cm_cnt;
        end
    end

    assign result.done        = done_q;
    assign result.timed_out   = timed_out_q;
    assign result.distance_cm = distance_q;

endmodule

// File: verilog/trig_scheduler.sv
module trig_scheduler
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  ranger_pkg::ranger_cfg_t  cfg,
    output logic                     trig,
    output logic                     arm
);

    import ranger_pkg::*;

    logic [cycle_width-1:0] period_cnt;
    logic                   trig_d;
    logic                   period_end;

    // Last cycle of the measurement period
    assign period_end = (period_cnt >= cfg.period - 1'b1);

    // Period counter, held at zero while disabled
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            period_cnt <= '0;
        else if (!cfg.enable)
            period_cnt <= '0;
        else if (period_end)
            period_cnt <= '0;
        else
            period_cnt <= period_cnt + 1'b1;
    end

    // Trig is registered, so it rises one cycle after count zero
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            trig   <= 1'b0;
            trig_d <= 1'b0;
        end
        else
        begin
            trig   <= cfg.enable && (period_cnt < cfg.trig_len);
            trig_d <= trig;
        end
    end

    // First low cycle after the pulse starts the echo window
    assign arm = trig_d & ~trig;

endmodule

// File: verilog/ranger_regs.sv
module ranger_regs
(
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [ranger_pkg::addr_width-1:0]   paddr,
    input  logic [ranger_pkg::reg_width-1:0]    pwdata,
    output logic [ranger_pkg::reg_width-1:0]    prdata,
    output logic                                pready,
    output logic                                pslverr,

    input  ranger_pkg::echo_result_t            result,
    output ranger_pkg::ranger_cfg_t             cfg,
    output logic                                irq
);

    import ranger_pkg::*;

    logic                   irq_en;
    logic                   res_valid;
    logic                   res_timed_out;
    logic [dist_width-1:0]  res_distance;
    logic [reg_width-1:0]   meas_count;

    logic                   access;
    logic                   wr_en;
    logic                   rd_result;
    logic                   addr_valid;
    logic                   addr_ro;

    // Address decode and read mux
    always_comb
    begin
        addr_valid = 1'b1;
        addr_ro    = 1'b0;
        prdata     = '0;
        case (paddr)
            reg_ctrl:
            begin
                prdata[ctrl_enable_bit] = cfg.enable;
                prdata[ctrl_irq_en_bit] = irq_en;
            end
            reg_period:        prdata[cycle_width-1:0] = cfg.period;
            reg_trig_len:      prdata[cycle_width-1:0] = cfg.trig_len;
            reg_cycles_per_cm: prdata[cycle_width-1:0] = cfg.cycles_per_cm;
            reg_timeout:       prdata[cycle_width-1:0] = cfg.timeout;
            reg_result:
            begin
                addr_ro                        = 1'b1;
                prdata[dist_width-1:0]         = res_distance;
                prdata[result_timed_out_bit]   = res_timed_out;
                prdata[result_valid_bit]       = res_valid;
            end
            reg_count:
            begin
                addr_ro = 1'b1;
                prdata  = meas_count;
            end
            default:           addr_valid = 1'b0;
        endcase
    end

    // Access phase of a transfer, no wait states
    assign access    = psel & penable;
    assign wr_en     = access & pwrite & addr_valid & ~addr_ro;
    assign rd_result = access & ~pwrite & (paddr == reg_result);

    assign pready  = 1'b1;
    assign pslverr = access & (~addr_valid | (pwrite & addr_ro));

    // Configuration registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cfg    <= '0;
            irq_en <= 1'b0;
        end
        else if (wr_en)
        begin
            case (paddr)
                reg_ctrl:
                begin
                    cfg.enable <= pwdata[ctrl_enable_bit];
                    irq_en     <= pwdata[ctrl_irq_en_bit];
                end
                reg_period:        cfg.period        <= pwdata[cycle_width-1:0];
                reg_trig_len:      cfg.trig_len      <= pwdata[cycle_width-1:0];
                reg_cycles_per_cm: cfg.cycles_per_cm <= pwdata[cycle_width-1:0];
                reg_timeout:       cfg.timeout       <= pwdata[cycle_width-1:0];
                default:           ;
            endcase
        end
    end

    // Result capture; a fresh result wins over a read in the same cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            res_valid     <= 1'b0;
            res_timed_out <= 1'b0;
            res_distance  <= '0;
            meas_count    <= '0;
        end
        else
        begin
            if (rd_result)
                res_valid <= 1'b0;          // Clear on read
            if (result.done)
            begin
                res_valid     <= 1'b1;
                res_timed_out <= result.timed_out;
                res_distance  <= result.distance_cm;
                meas_count    <= meas_count + 1'b1;
            end
        end
    end

    // Level interrupt while an unread result is pending
    assign irq = res_valid & irq_en;

endmodule

// File: verilog/ranger_pkg.sv
package ranger_pkg;

    // Field widths
    localparam int cycle_width = 24;  // 200 ms at 50 MHz fits
    localparam int dist_width  = 16;
    localparam int reg_width   = 32;
    localparam int addr_width  = 8;

    // Distance reported when the echo outlasts the timeout
    localparam logic [dist_width-1:0] dist_overflow = '1;

    // APB register map
    localparam logic [addr_width-1:0] reg_ctrl          = 8'h00;
    localparam logic [addr_width-1:0] reg_period        = 8'h04;
    localparam logic [addr_width-1:0] reg_trig_len      = 8'h08;
    localparam logic [addr_width-1:0] reg_cycles_per_cm = 8'h0C;
    localparam logic [addr_width-1:0] reg_timeout       = 8'h10;
    localparam logic [addr_width-1:0] reg_result        = 8'h14;  // Read only
    localparam logic [addr_width-1:0] reg_count         = 8'h18;  // Read only

    // Bit positions inside the control and result registers
    localparam int ctrl_enable_bit      = 0;
    localparam int ctrl_irq_en_bit      = 1;
    localparam int result_timed_out_bit = 16;
    localparam int result_valid_bit     = 31;

    // Run-time configuration, all timings in clock cycles
    typedef struct packed {
        logic                   enable;
        logic [cycle_width-1:0] period;
        logic [cycle_width-1:0] trig_len;
        logic [cycle_width-1:0] cycles_per_cm;
        logic [cycle_width-1:0] timeout;
    } ranger_cfg_t;

    // One completed measurement
    typedef struct packed {
        logic                  done;         // Single-cycle strobe
        logic                  timed_out;
        logic [dist_width-1:0] distance_cm;
    } echo_result_t;

endpackage
